//--- build.f
+incdir+include
src/rv_core_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/mem_arbiter.sv
src/rv_core_top.sv
testbench/tb_rv_model.sv
testbench/tb_rv_core.sv

//--- include/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// ********************************************************************
// Core widths and reset vector
// ********************************************************************
`define XLEN      32
`define RESET_PC  32'h0000_0000

// ********************************************************************
// RV32I opcodes of the supported subset
// ********************************************************************
`define OP_LUI    7'b0110111
`define OP_OP_IMM 7'b0010011
`define OP_OP     7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// ALU funct3 values, shared by OP and OP-IMM
`define F3_ADD    3'b000
`define F3_SLL    3'b001
`define F3_SLT    3'b010
`define F3_SLTU   3'b011
`define F3_XOR    3'b100
`define F3_SRL    3'b101
`define F3_OR     3'b110
`define F3_AND    3'b111

`define F3_LW     3'b010
`define F3_SW     3'b010

`endif

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 f_req_i,
  input  rv_core_pkg::word_t  f_addr_i,
  input  wire                 e_req_i,
  input  wire                 e_we_i,
  input  rv_core_pkg::word_t  e_addr_i,
  input  rv_core_pkg::word_t  e_wdata_i,
  input  wire                 mem_rvalid_i,
  input  rv_core_pkg::word_t  mem_rdata_i,
  output logic                f_gnt_o,
  output logic                f_rvalid_o,
  output logic                e_gnt_o,
  output logic                e_rvalid_o,
  output rv_core_pkg::word_t  rdata_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output rv_core_pkg::word_t  mem_addr_o,
  output rv_core_pkg::word_t  mem_wdata_o
);

  rv_core_pkg::arb_owner_e owner_q;
  logic                    idle;

  assign idle    = (owner_q == rv_core_pkg::OWN_NONE);
  assign e_gnt_o = idle && e_req_i;               // Execute has priority
  assign f_gnt_o = idle && f_req_i && !e_req_i;

  assign mem_req_o   = e_gnt_o || f_gnt_o;
  assign mem_we_o    = e_gnt_o && e_we_i;
  assign mem_addr_o  = e_gnt_o ? e_addr_i : f_addr_i;
  assign mem_wdata_o = e_gnt_o ? e_wdata_i : '0;

  // Response goes back to whoever owns the outstanding request
  assign f_rvalid_o = mem_rvalid_i && (owner_q == rv_core_pkg::OWN_FETCH);
  assign e_rvalid_o = mem_rvalid_i && (owner_q == rv_core_pkg::OWN_EXEC);
  assign rdata_o    = mem_rdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner_q <= rv_core_pkg::OWN_NONE;
    end else if (e_gnt_o) begin
      owner_q <= rv_core_pkg::OWN_EXEC;
    end else if (f_gnt_o) begin
      owner_q <= rv_core_pkg::OWN_FETCH;
    end else if (mem_rvalid_i) begin
      owner_q <= rv_core_pkg::OWN_NONE;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_core_pkg.sv
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [31:0]      inst_t;
  typedef logic [4:0]       reg_addr_t;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_kind_e;

  typedef enum logic {EX_IDLE, EX_MEM_WAIT} exec_state_e;

  typedef enum logic [1:0] {OWN_NONE, OWN_FETCH, OWN_EXEC} arb_owner_e;

endpackage

`default_nettype wire

//--- src/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     mem_rvalid_i,
  input  rv_core_pkg::word_t      mem_rdata_i,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output rv_core_pkg::word_t      mem_addr_o,
  output rv_core_pkg::word_t      mem_wdata_o,
  output logic                    wb_valid_o,
  output rv_core_pkg::reg_addr_t  wb_rd_o,
  output rv_core_pkg::word_t      wb_data_o
);

  logic                    fetch_valid;
  rv_core_pkg::inst_t      fetch_inst;
  rv_core_pkg::word_t      fetch_pc;   // Observed by the testbench
  logic                    dec_ready;
  logic                    f_req;
  rv_core_pkg::word_t      f_addr;
  logic                    f_gnt;
  logic                    f_rvalid;
  rv_core_pkg::word_t      arb_rdata;
  rv_core_pkg::reg_addr_t  rs1;
  rv_core_pkg::reg_addr_t  rs2;
  rv_core_pkg::word_t      rs1_data;
  rv_core_pkg::word_t      rs2_data;
  logic [31:0]             busy;
  logic                    ex_valid;
  logic                    ex_ready;
  rv_core_pkg::alu_op_e    alu_op;
  rv_core_pkg::word_t      op_a;
  rv_core_pkg::word_t      op_b;
  rv_core_pkg::word_t      store_data;
  rv_core_pkg::reg_addr_t  rd;
  logic                    rd_we;
  rv_core_pkg::mem_kind_e  mem_kind;
  logic                    issue;
  logic                    e_req;
  logic                    e_we;
  rv_core_pkg::word_t      e_addr;
  rv_core_pkg::word_t      e_wdata;
  logic                    e_gnt;
  logic                    e_rvalid;

  rv_fetch rv_fetch_i (
    .clk(clk), .rst(rst), .gnt_i(f_gnt), .rvalid_i(f_rvalid), .rdata_i(arb_rdata),
    .ready_i(dec_ready), .req_o(f_req), .addr_o(f_addr), .valid_o(fetch_valid),
    .inst_o(fetch_inst), .pc_o(fetch_pc)
  );

  rv_decode rv_decode_i (
    .clk(clk), .rst(rst), .valid_i(fetch_valid), .inst_i(fetch_inst), .ready_i(ex_ready),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .busy_i(busy), .ready_o(dec_ready),
    .valid_o(ex_valid), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .rd_we_o(rd_we),
    .alu_op_o(alu_op), .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data),
    .mem_kind_o(mem_kind), .issue_o(issue)
  );

  rv_regfile rv_regfile_i (
    .clk(clk), .rst(rst), .rs1_i(rs1), .rs2_i(rs2), .issue_i(issue), .issue_rd_i(rd),
    .wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .busy_o(busy)
  );

  rv_execute rv_execute_i (
    .clk(clk), .rst(rst), .valid_i(ex_valid), .alu_op_i(alu_op), .op_a_i(op_a),
    .op_b_i(op_b), .store_data_i(store_data), .rd_i(rd), .rd_we_i(rd_we),
    .mem_kind_i(mem_kind), .gnt_i(e_gnt), .rvalid_i(e_rvalid), .rdata_i(arb_rdata),
    .ready_o(ex_ready), .req_o(e_req), .we_o(e_we), .addr_o(e_addr), .wdata_o(e_wdata),
    .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
  );

  mem_arbiter mem_arbiter_i (
    .clk(clk), .rst(rst), .f_req_i(f_req), .f_addr_i(f_addr), .e_req_i(e_req),
    .e_we_i(e_we), .e_addr_i(e_addr), .e_wdata_i(e_wdata), .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i(mem_rdata_i), .f_gnt_o(f_gnt), .f_rvalid_o(f_rvalid), .e_gnt_o(e_gnt),
    .e_rvalid_o(e_rvalid), .rdata_o(arb_rdata), .mem_req_o(mem_req_o),
    .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
  );

endmodule

`default_nettype wire

//--- src/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_decode (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        valid_i,
  input  rv_core_pkg::inst_t         inst_i,
  input  wire                        ready_i,
  input  rv_core_pkg::word_t         rs1_data_i,
  input  rv_core_pkg::word_t         rs2_data_i,
  input  wire [31:0]                 busy_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output rv_core_pkg::reg_addr_t     rs1_o,
  output rv_core_pkg::reg_addr_t     rs2_o,
  output rv_core_pkg::reg_addr_t     rd_o,
  output logic                       rd_we_o,
  output rv_core_pkg::alu_op_e       alu_op_o,
  output rv_core_pkg::word_t         op_a_o,
  output rv_core_pkg::word_t         op_b_o,
  output rv_core_pkg::word_t         store_data_o,
  output rv_core_pkg::mem_kind_e     mem_kind_o,
  output logic                       issue_o
);

  function automatic rv_core_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      `F3_ADD:  f3_to_alu = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      `F3_SLL:  f3_to_alu = rv_core_pkg::ALU_SLL;
      `F3_SLT:  f3_to_alu = rv_core_pkg::ALU_SLT;
      `F3_SLTU: f3_to_alu = rv_core_pkg::ALU_SLTU;
      `F3_XOR:  f3_to_alu = rv_core_pkg::ALU_XOR;
      `F3_SRL:  f3_to_alu = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      `F3_OR:   f3_to_alu = rv_core_pkg::ALU_OR;
      default:  f3_to_alu = rv_core_pkg::ALU_AND;
    endcase
  endfunction

  rv_core_pkg::inst_t inst_q;
  logic               valid_q;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               alt;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_u;
  logic               writes;
  logic               use_rs1;
  logic               use_rs2;
  logic               stall;
  logic               fire;

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign alt    = inst_q[30];
  assign rs1_o  = inst_q[19:15];
  assign rs2_o  = inst_q[24:20];
  assign rd_o   = inst_q[11:7];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_u = {inst_q[31:12], 12'b0};

  // ********************************************************************
  // Operand and operation select
  // ********************************************************************
  always_comb begin
    writes     = 1'b0;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    alu_op_o   = rv_core_pkg::ALU_ADD;
    op_a_o     = rs1_data_i;
    op_b_o     = imm_i;
    mem_kind_o = rv_core_pkg::MEM_NONE;
    case (opcode)
      `OP_LUI: begin
        writes = 1'b1;
        op_a_o = '0;
        op_b_o = imm_u;
      end
      `OP_OP_IMM: begin
        writes   = 1'b1;
        use_rs1  = 1'b1;
        alu_op_o = f3_to_alu(funct3, alt && (funct3 == `F3_SRL));  // Only srai uses bit 30
      end
      `OP_OP: begin
        writes   = 1'b1;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        alu_op_o = f3_to_alu(funct3, alt);
        op_b_o   = rs2_data_i;
      end
      `OP_LOAD: begin
        writes     = 1'b1;
        use_rs1    = 1'b1;
        mem_kind_o = rv_core_pkg::MEM_LOAD;
      end
      `OP_STORE: begin
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
        op_b_o     = imm_s;
        mem_kind_o = rv_core_pkg::MEM_STORE;
      end
      default: begin
      end
    endcase
  end

  assign store_data_o = rs2_data_i;
  assign rd_we_o      = writes && (rd_o != 5'd0);

  // Scoreboard check against the busy table
  assign stall   = (use_rs1 && busy_i[rs1_o]) || (use_rs2 && busy_i[rs2_o]);
  assign valid_o = valid_q && !stall;
  assign fire    = valid_o && ready_i;
  assign ready_o = !valid_q || fire;
  assign issue_o = fire && rd_we_o;  // Marks rd busy in the register file

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (fire) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      inst_q <= inst_i;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     valid_i,
  input  rv_core_pkg::alu_op_e    alu_op_i,
  input  rv_core_pkg::word_t      op_a_i,
  input  rv_core_pkg::word_t      op_b_i,
  input  rv_core_pkg::word_t      store_data_i,
  input  rv_core_pkg::reg_addr_t  rd_i,
  input  wire                     rd_we_i,
  input  rv_core_pkg::mem_kind_e  mem_kind_i,
  input  wire                     gnt_i,
  input  wire                     rvalid_i,
  input  rv_core_pkg::word_t      rdata_i,
  output logic                    ready_o,
  output logic                    req_o,
  output logic                    we_o,
  output rv_core_pkg::word_t      addr_o,
  output rv_core_pkg::word_t      wdata_o,
  output logic                    wb_valid_o,
  output rv_core_pkg::reg_addr_t  wb_rd_o,
  output rv_core_pkg::word_t      wb_data_o
);

  rv_core_pkg::exec_state_e state_q;
  rv_core_pkg::word_t       alu_res;
  rv_core_pkg::word_t       addr_q;
  rv_core_pkg::word_t       wdata_q;
  logic                     rd_we_q;
  logic                     we_q;
  logic                     sent_q;
  logic                     accept;
  logic                     mem_op;

  always_comb begin
    case (alu_op_i)
      rv_core_pkg::ALU_SUB:  alu_res = op_a_i - op_b_i;
      rv_core_pkg::ALU_SLL:  alu_res = op_a_i << op_b_i[4:0];
      rv_core_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a_i) < $signed(op_b_i)};
      rv_core_pkg::ALU_SLTU: alu_res = {31'b0, op_a_i < op_b_i};
      rv_core_pkg::ALU_XOR:  alu_res = op_a_i ^ op_b_i;
      rv_core_pkg::ALU_SRL:  alu_res = op_a_i >> op_b_i[4:0];
      rv_core_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a_i) >>> op_b_i[4:0]);
      rv_core_pkg::ALU_OR:   alu_res = op_a_i | op_b_i;
      rv_core_pkg::ALU_AND:  alu_res = op_a_i & op_b_i;
      default:               alu_res = op_a_i + op_b_i;  // Also the load/store address
    endcase
  end

  assign ready_o = (state_q == rv_core_pkg::EX_IDLE);
  assign accept  = valid_i && ready_o;
  assign mem_op  = (mem_kind_i != rv_core_pkg::MEM_NONE);
  assign req_o   = (state_q == rv_core_pkg::EX_MEM_WAIT) && !sent_q;  // Held until granted
  assign we_o    = we_q;
  assign addr_o  = addr_q;
  assign wdata_o = wdata_q;

  // ********************************************************************
  // Control state
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= rv_core_pkg::EX_IDLE;
      sent_q     <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= 1'b0;
      case (state_q)
        rv_core_pkg::EX_IDLE: begin
          if (accept && mem_op) begin
            state_q <= rv_core_pkg::EX_MEM_WAIT;
            sent_q  <= 1'b0;
          end else if (accept) begin
            wb_valid_o <= rd_we_i;
          end
        end
        default: begin
          if (gnt_i) begin
            sent_q <= 1'b1;
          end
          if (rvalid_i) begin
            state_q    <= rv_core_pkg::EX_IDLE;
            wb_valid_o <= rd_we_q;  // Stores have no writeback
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= alu_res;
      wdata_q <= store_data_i;
      we_q    <= (mem_kind_i == rv_core_pkg::MEM_STORE);
      rd_we_q <= rd_we_i;
      wb_rd_o   <= rd_i;
      wb_data_o <= alu_res;
    end else if ((state_q == rv_core_pkg::EX_MEM_WAIT) && rvalid_i) begin
      wb_data_o <= rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_fetch (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 gnt_i,
  input  wire                 rvalid_i,
  input  rv_core_pkg::inst_t  rdata_i,
  input  wire                 ready_i,
  output logic                req_o,
  output rv_core_pkg::word_t  addr_o,
  output logic                valid_o,
  output rv_core_pkg::inst_t  inst_o,
  output rv_core_pkg::word_t  pc_o
);

  rv_core_pkg::word_t pc_q;
  rv_core_pkg::word_t inst_pc_q;
  rv_core_pkg::inst_t buf_inst_q;
  logic               buf_valid_q;
  logic               pending_q;

  assign req_o   = !rst && !buf_valid_q && !pending_q;  // One fetch in flight at most
  assign addr_o  = pc_q;
  assign valid_o = buf_valid_q;
  assign inst_o  = buf_inst_q;
  assign pc_o    = inst_pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `RESET_PC;
      pending_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (gnt_i) begin
        pc_q      <= pc_q + 32'd4;
        pending_q <= 1'b1;
      end
      if (rvalid_i) begin
        pending_q   <= 1'b0;
        buf_valid_q <= 1'b1;
      end else if (valid_o && ready_i) begin
        buf_valid_q <= 1'b0;  // Decode took the word
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_i) begin
      inst_pc_q <= pc_q;
    end
    if (rvalid_i) begin
      buf_inst_q <= rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                     clk,
  input  wire                     rst,
  input  rv_core_pkg::reg_addr_t  rs1_i,
  input  rv_core_pkg::reg_addr_t  rs2_i,
  input  wire                     issue_i,
  input  rv_core_pkg::reg_addr_t  issue_rd_i,
  input  wire                     wb_valid_i,
  input  rv_core_pkg::reg_addr_t  wb_rd_i,
  input  rv_core_pkg::word_t      wb_data_i,
  output rv_core_pkg::word_t      rs1_data_o,
  output rv_core_pkg::word_t      rs2_data_o,
  output logic [31:0]             busy_o
);

  rv_core_pkg::word_t regs_q [1:31];
  logic [31:0]        busy_q;

  assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs_q[rs1_i];  // x0 is hardwired to zero
  assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs_q[rs2_i];
  assign busy_o     = busy_q;

  always_ff @(posedge clk) begin
    if (wb_valid_i && (wb_rd_i != 5'd0)) begin
      regs_q[wb_rd_i] <= wb_data_i;
    end
  end

  // Set after clear, so a new issue to the same rd keeps the bit
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (wb_valid_i) begin
        busy_q[wb_rd_i] <= 1'b0;
      end
      if (issue_i && (issue_rd_i != 5'd0)) begin
        busy_q[issue_rd_i] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module tb_rv_core;

  localparam int PROG_WORDS = 512;
  localparam int WB_TARGET  = 400;
  localparam int MAX_CYCLES = 20000;

  logic        clk;
  logic        rst;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  logic [31:0] mem [0:1023];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_val_q [$];
  logic [31:0] exp_st_addr_q [$];
  logic [31:0] exp_st_data_q [$];
  integer      seed;
  int          wb_count;
  int          wb_err;
  int          st_err;
  int          fetch_err;
  int          proto_err;
  int          cycles;
  logic        prev_req;
  logic        first_cycle;
  logic        reset_seen;
  logic [31:0] next_fetch;
  logic [31:0] next_accept;

  rv_core_top rv_core_top_i (
    .clk(clk), .rst(rst), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
  );

  tb_rv_model model_i ();

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int err_cnt);
    assert (got === exp) else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // ********************************************************************
  // Random program and expected events
  // ********************************************************************
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] inst;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] off;
    logic [19:0] recent;
    logic        wb;
    logic [4:0]  wrd;
    logic [31:0] value;
    logic        st;
    logic [31:0] addr;
    logic [31:0] data;
    model_i.clear_state();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = model_i.fill_value(i * 4);
    end
    recent = 20'd0;  // Sources read x0 until registers get written
    for (int i = 0; i < PROG_WORDS; i++) begin
      r   = $random(seed);
      rd  = (r[6:3] == 4'd0) ? {4'd0, r[15]} : {1'b0, r[6:3]};  // Now and then x0
      rs1 = recent[r[8:7] * 5 +: 5];
      rs2 = recent[r[10:9] * 5 +: 5];
      f3  = r[13:11];
      off = {1'b1, r[20:16], 6'b0};
      case (r[2:0])
        3'd0: inst = {r[31:12], rd, `OP_LUI};
        3'd1, 3'd2: begin
          imm = r[25:14];
          if (f3 == `F3_SLL) begin
            imm = {7'b0, r[18:14]};
          end else if (f3 == `F3_SRL) begin
            imm = {1'b0, r[26], 5'b0, r[18:14]};
          end
          inst = {imm, rs1, f3, rd, `OP_OP_IMM};
        end
        3'd5: inst = {off, 5'd0, `F3_LW, rd, `OP_LOAD};
        3'd6: inst = {off[11:5], rs2, 5'd0, `F3_SW, off[4:0], `OP_STORE};
        default: begin
          inst = {1'b0, r[26] && ((f3 == `F3_ADD) || (f3 == `F3_SRL)), 5'b0,
                  rs2, rs1, f3, rd, `OP_OP};
        end
      endcase
      mem[i] = inst;
      model_i.step_inst(inst, wb, wrd, value, st, addr, data);
      if (wb) begin
        exp_rd_q.push_back(wrd);
        exp_val_q.push_back(value);
      end
      if (st) begin
        exp_st_addr_q.push_back(addr);
        exp_st_data_q.push_back(data);
      end
      if (r[2:0] != 3'd6) begin
        recent = {recent[14:0], rd};
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Memory answers each request one cycle later
  always @(posedge clk) begin
    mem_rvalid <= mem_req && !rst;
    if (mem_req && !rst) begin
      if (mem_we) begin
        mem[mem_addr[11:2]] = mem_wdata;
      end else begin
        mem_rdata <= mem[mem_addr[11:2]];
      end
    end
  end

  // ********************************************************************
  // Checks on every observed event
  // ********************************************************************
  always @(posedge clk) begin
    if (rst) begin
      if (reset_seen) begin
        compare_value("mem_req_o", {31'b0, mem_req}, 32'd0, proto_err);
        compare_value("mem_we_o", {31'b0, mem_we}, 32'd0, proto_err);
        compare_value("wb_valid_o", {31'b0, wb_valid}, 32'd0, proto_err);
      end
      reset_seen  = 1'b1;
      prev_req    = 1'b0;
      first_cycle = 1'b1;
      next_fetch  = `RESET_PC;
      next_accept = `RESET_PC;
    end else begin
      if (first_cycle) begin
        compare_value("mem_req_o", {31'b0, mem_req}, 32'd1, proto_err);
        compare_value("mem_we_o", {31'b0, mem_we}, 32'd0, proto_err);
        compare_value("wb_valid_o", {31'b0, wb_valid}, 32'd0, proto_err);
        first_cycle = 1'b0;
      end
      assert (!(mem_req && prev_req)) else begin
        $display("Memory request at t=%0t while another was outstanding", $time);
        proto_err++;
      end
      prev_req = mem_req;
      if (mem_req && !mem_we && (mem_addr[31:12] == 20'd0)) begin
        compare_value("mem_addr_o (fetch)", mem_addr, next_fetch, fetch_err);
        next_fetch = next_fetch + 32'd4;
      end
      if (rv_core_top_i.fetch_valid && rv_core_top_i.dec_ready) begin
        compare_value("fetch_pc", rv_core_top_i.fetch_pc, next_accept, fetch_err);
        next_accept = next_accept + 32'd4;
      end
      if (mem_req && mem_we) begin
        if (exp_st_addr_q.size() == 0) begin
          $display("Store at t=%0t with no store left in the program", $time);
          st_err++;
        end else begin
          compare_value("mem_addr_o (store)", mem_addr, exp_st_addr_q.pop_front(), st_err);
          compare_value("mem_wdata_o", mem_wdata, exp_st_data_q.pop_front(), st_err);
        end
      end
      if (wb_valid) begin
        assert (wb_rd != 5'd0) else begin
          $display("Writeback to x0 at t=%0t", $time);
          wb_err++;
        end
        if (exp_rd_q.size() == 0) begin
          $display("Writeback at t=%0t with no instruction left to retire", $time);
          wb_err++;
        end else begin
          compare_value("wb_rd_o", {27'b0, wb_rd}, {27'b0, exp_rd_q.pop_front()}, wb_err);
          compare_value("wb_data_o", wb_data, exp_val_q.pop_front(), wb_err);
        end
        wb_count++;
      end
    end
  end

  initial begin
    seed       = 32'hb55c31b1;
    wb_count   = 0;
    wb_err     = 0;
    st_err     = 0;
    fetch_err  = 0;
    proto_err  = 0;
    reset_seen = 1'b0;
    rst        <= 1'b1;
    mem_rvalid <= 1'b0;
    mem_rdata  <= 32'd0;
    build_program();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while ((wb_count < WB_TARGET) && (cycles < MAX_CYCLES)) begin
      @(negedge clk);
      cycles++;
    end
    if (wb_count < WB_TARGET) begin
      $display("Timeout after %0d cycles, only %0d writebacks seen", cycles, wb_count);
      proto_err++;
    end
    $display("Errors: writeback=%0d store=%0d fetch=%0d protocol=%0d",
             wb_err, st_err, fetch_err, proto_err);
    if ((wb_err + st_err + fetch_err + proto_err) == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_rv_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module tb_rv_model;

  logic [31:0] regs [0:31];
  logic [31:0] dmem [0:1023];  // Indexed by address bits 11:2, like the memory model

  function automatic logic [31:0] fill_value(input logic [31:0] addr);
    fill_value = (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  task automatic clear_state();
    for (int i = 0; i < 32; i++) begin
      regs[i] = 32'd0;
    end
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = fill_value(i * 4);
    end
  endtask

  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    case (f3)
      `F3_ADD:  res = alt ? (a - b) : (a + b);
      `F3_SLL:  res = a << b[4:0];
      `F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      `F3_XOR:  res = a ^ b;
      `F3_SRL: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      `F3_OR:   res = a | b;
      default:  res = a & b;
    endcase
    alu = res;
  endfunction

  // Retires one instruction and reports its writeback and its store
  task automatic step_inst(input logic [31:0] inst, output logic wb, output logic [4:0] rd,
                           output logic [31:0] value, output logic st,
                           output logic [31:0] addr, output logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    a     = regs[inst[19:15]];
    b     = regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    rd    = inst[11:7];
    wb    = 1'b1;
    st    = 1'b0;
    value = 32'd0;
    addr  = 32'd0;
    data  = b;
    case (inst[6:0])
      `OP_LUI:    value = {inst[31:12], 12'h000};
      `OP_OP_IMM: value = alu(inst[14:12], inst[30] && (inst[14:12] == `F3_SRL), a, imm_i);
      `OP_OP:     value = alu(inst[14:12], inst[30], a, b);
      `OP_LOAD: begin
        addr  = a + imm_i;
        value = dmem[addr[11:2]];
      end
      `OP_STORE: begin
        addr = a + imm_s;
        st   = 1'b1;
        wb   = 1'b0;
        dmem[addr[11:2]] = b;
      end
      default: wb = 1'b0;  // Unknown opcodes retire as no-ops
    endcase
    if (rd == 5'd0) begin
      wb = 1'b0;
    end
    if (wb) begin
      regs[rd] = value;
    end
  endtask

endmodule

`default_nettype wire
